// ==== sim/enc_stim.txt ====
# Columns: op, then operands. W addr data, R addr expected, P expected are hex.
# S steps period and I cycles are decimal, steps signed. F takes no operand.
# Velocity first, windows close 1000 cycles apart from reset release
S 700 4
R 5 3
R 4 FA
R 5 1
R 3 2BC
S -700 4
R 5 3
R 4 FFFFFF06
R 5 1
R 3 0
# Counting from a cleared count, then below zero
W 1 1
R 3 0
S 25 4
S -10 4
R 3 F
S -30 4
R 3 FFFFFFF1
# Preset load, clear, clear wins over load
W 2 1000
W 1 4
R 3 1000
S 5 4
R 3 1005
R 2 1000
W 1 5
R 3 0
W 1 4
R 3 1000
W 1 1
R 3 0
# Enable off holds the count, on resumes
W 0 0
R 0 0
S 8 4
R 3 0
W 0 1
R 0 1
S 6 4
R 3 6
# Fault, a window has closed since the last velocity read
P 1
R 5 3
F
P 0
R 5 2
R 3 6
S 4 4
R 3 A
W 1 2
P 1
R 5 3
# Register map
I 20
R 1 0
R 6 0
W 7 FFFFFFFF
R 7 0
W 0 1
R 0 1

// ==== sources.f ====
+incdir+.
logic/enc_types_pkg.sv
logic/enc_reg_pkg.sv
logic/enc_ctrl_if.sv
logic/quad_decoder.sv
logic/velocity_meter.sv
logic/enc_regs.sv
logic/enc_top.sv
sim/enc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the encoder interface testbench with Verilator.
# Exit status is nonzero if the build fails or the simulation ends in $fatal.

set -u

cd "$(dirname "$0")" || exit 1

TOP=enc_tb
OBJ_DIR=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

if ! rm -rf "$OBJ_DIR"; then
  echo "could not remove old build directory $OBJ_DIR"
  exit 1
fi

if ! verilator --binary --timing -f sources.f --top-module "$TOP" -Mdir "$OBJ_DIR"; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ_DIR/V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit "$status"
fi

echo "simulation exited cleanly"
exit 0

// ==== sim/enc_tb.sv ====
`timescale 1ns/1ps
`include "enc_cfg.svh"

module enc_tb;
  import enc_reg_pkg::*;

  localparam string STIM_FILE       = "sim/enc_stim.txt";
  localparam int    HALF_PERIOD     = 50;  // 100 ns clock
  localparam int    DRIVE_DLY       = 5;   // Input skew after rising edge
  localparam int    RESET_CYCLES    = 8;
  localparam int    SETTLE_CYCLES   = 6;   // Sync stages plus count register and margin
  localparam int    BUS_LINE_CYCLES = 20;  // Timeout budget per W, R, P, F line

  logic      clk;
  logic      resetn;
  logic      enc_a;
  logic      enc_b;
  reg_addr_t bus_addr;
  reg_data_t bus_wdata;
  logic      bus_wr;
  logic      bus_rd;
  reg_data_t bus_rdata;
  logic      faultn;

  logic [7:0]  op_q[$];      // Parsed opcodes
  logic [31:0] arg1_q[$];    // First operand per line
  logic [31:0] arg2_q[$];    // Second operand per line
  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  bit          limit_ready = 1'b0;
  int          phase;        // Position in the Gray cycle, 0 to 3

  enc_top DUT (
    .clk       (clk),
    .resetn    (resetn),
    .enc_a     (enc_a),
    .enc_b     (enc_b),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_wr    (bus_wr),
    .bus_rd    (bus_rd),
    .bus_rdata (bus_rdata),
    .faultn    (faultn)
  );

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Watchdog on total run length
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (limit_ready && (cycle_cnt >= cycle_limit)) begin
      $display("Timeout after %0d cycles, stimulus did not finish", cycle_cnt);
      $display("TESTBENCH FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "value check failed");
    end
  endtask

  // Cycles a stim line is expected to take
  function automatic int line_cycles(input logic [7:0] op, input logic [31:0] arg1,
                                     input logic [31:0] arg2);
    int n;
    n = arg1;
    if (op == "S") begin
      return ((n < 0) ? -n : n) * int'(arg2);
    end else if (op == "I") begin
      return n;
    end
    return BUS_LINE_CYCLES;
  endfunction

  task automatic load_stim();
    int                 fd;
    int                 rc;
    int                 need;   // Operand count of the opcode or -1 if unknown
    int                 num1;
    int                 num2;
    int                 total;
    bit                 done;
    logic [7:0]         op;
    logic [31:0]        hex1;
    logic [31:0]        hex2;
    logic [8*160-1:0]   rest;   // Remainder of a comment line
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open stimulus file %s", STIM_FILE);
      $display("TESTBENCH FAILED");
      $fatal(1, "stimulus file missing");
    end
    total = RESET_CYCLES;
    done  = 1'b0;
    while (!done) begin
      rc = $fscanf(fd, "%s", op);
      if (rc != 1) begin
        done = 1'b1;                          // End of file
      end else if (op == "#") begin
        rc = $fgets(rest, fd);                // Drop comment text
      end else begin
        hex1 = '0;
        hex2 = '0;
        need = -1;
        if (op == "W" || op == "R") begin
          rc   = $fscanf(fd, "%h %h", hex1, hex2);
          need = 2;
        end else if (op == "P") begin
          rc   = $fscanf(fd, "%h", hex1);
          need = 1;
        end else if (op == "S") begin
          rc   = $fscanf(fd, "%d %d", num1, num2);  // Signed count and period
          hex1 = num1;
          hex2 = num2;
          need = 2;
        end else if (op == "I") begin
          rc   = $fscanf(fd, "%d", num1);
          hex1 = num1;
          need = 1;
        end else if (op == "F") begin
          rc   = 0;
          need = 0;
        end
        if (need < 0) begin
          $display("Unknown opcode '%c' in stimulus file", op);
          $display("TESTBENCH FAILED");
          $fatal(1, "bad stimulus opcode");
        end else if (rc != need) begin
          $display("Missing operands after opcode '%c' in stimulus file", op);
          $display("TESTBENCH FAILED");
          $fatal(1, "bad stimulus line");
        end else begin
          op_q.push_back(op);
          arg1_q.push_back(hex1);
          arg2_q.push_back(hex2);
          total = total + line_cycles(op, hex1, hex2);
        end
      end
    end
    $fclose(fd);
    cycle_limit = 2 * total;                  // Generous margin over nominal
    limit_ready = 1'b1;
    $display("Loaded %0d stimulus lines, cycle limit %0d", op_q.size(), cycle_limit);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // Phase order BA = 00 01 11 10 with A leading when counting up
  task automatic drive_phase();
    enc_a = (phase == 1) || (phase == 2);
    enc_b = (phase == 2) || (phase == 3);
  endtask

  task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
    bus_addr  = addr;
    bus_wdata = data;
    bus_wr    = 1'b1;
    next_cycle();                             // Strobe sampled here
    bus_wr    = 1'b0;
  endtask

  task automatic bus_read_check(input reg_addr_t addr, input reg_data_t expected);
    repeat (SETTLE_CYCLES) next_cycle();
    bus_addr = addr;
    bus_rd   = 1'b1;
    next_cycle();                             // bus_rdata loads on this edge
    bus_rd   = 1'b0;
    check_value($sformatf("bus_rdata[addr %0h]", addr), bus_rdata, expected);
  endtask

  task automatic run_steps(input int n, input int p);
    int count;
    count = (n < 0) ? -n : n;
    for (int i = 0; i < count; i++) begin
      phase = (n > 0) ? ((phase + 1) % 4) : ((phase + 3) % 4);
      drive_phase();
      repeat (p) next_cycle();
    end
  endtask

  // Skip two phases so both pins move together
  task automatic double_change();
    phase = (phase + 2) % 4;
    drive_phase();
    next_cycle();
  endtask

  task automatic check_faultn(input logic [31:0] expected);
    repeat (SETTLE_CYCLES) next_cycle();
    check_value("faultn", {31'b0, faultn}, expected);
  endtask

  task automatic run_line(input logic [7:0] op, input logic [31:0] arg1,
                          input logic [31:0] arg2);
    case (op)
      "W":     bus_write(arg1[`ENC_ADDR_W-1:0], arg2);
      "R":     bus_read_check(arg1[`ENC_ADDR_W-1:0], arg2);
      "S":     run_steps(arg1, arg2);
      "F":     double_change();
      "I":     repeat (int'(arg1)) next_cycle();
      "P":     check_faultn(arg1);
      default: next_cycle();                  // Parser rejects anything else
    endcase
  endtask

  initial begin
    resetn    = 1'b0;
    enc_a     = 1'b0;
    enc_b     = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    bus_wr    = 1'b0;
    bus_rd    = 1'b0;
    phase     = 0;
    load_stim();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    resetn = 1'b1;                            // Gate window starts counting here
    for (int i = 0; i < op_q.size(); i++) begin
      run_line(op_q[i], arg1_q[i], arg2_q[i]);
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// ==== logic/enc_top.sv ====
`timescale 1ns/1ps

module enc_top (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   enc_a,      // Encoder channel A
  input  logic                   enc_b,      // Encoder channel B
  input  enc_reg_pkg::reg_addr_t bus_addr,
  input  enc_reg_pkg::reg_data_t bus_wdata,
  input  logic                   bus_wr,
  input  logic                   bus_rd,
  output enc_reg_pkg::reg_data_t bus_rdata,
  output logic                   faultn      // To drive-enable interlock
);

  logic step;  // Decoder to meter
  logic dir;

  enc_ctrl_if ctrl_if ();  // Controls and measurements

  enc_regs u_regs (
    .clk       (clk),
    .resetn    (resetn),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_wr    (bus_wr),
    .bus_rd    (bus_rd),
    .bus_rdata (bus_rdata),
    .ctrl      (ctrl_if.regs)
  );

  quad_decoder u_dec (
    .clk    (clk),
    .resetn (resetn),
    .a      (enc_a),
    .b      (enc_b),
    .ctrl   (ctrl_if.dec),
    .step   (step),
    .dir    (dir)
  );

  velocity_meter u_vel (
    .clk    (clk),
    .resetn (resetn),
    .step   (step),
    .dir    (dir),
    .ctrl   (ctrl_if.vel)
  );

  assign faultn = ctrl_if.faultn;  // Same flag as REG_STATUS bit 0

endmodule

// ==== logic/enc_regs.sv ====
`timescale 1ns/1ps
`include "enc_cfg.svh"

module enc_regs (
  input  logic                   clk,
  input  logic                   resetn,
  input  enc_reg_pkg::reg_addr_t bus_addr,
  input  enc_reg_pkg::reg_data_t bus_wdata,
  input  logic                   bus_wr,     // One-cycle write strobe
  input  logic                   bus_rd,     // One-cycle read strobe
  output enc_reg_pkg::reg_data_t bus_rdata,  // Valid cycle after bus_rd
  enc_ctrl_if.regs               ctrl
);
  import enc_reg_pkg::*;
  import enc_types_pkg::*;

  logic        wr_ctrl;    // Write hits REG_CTRL
  logic        wr_cmd;     // Write hits REG_CMD
  logic        wr_preset;  // Write hits REG_PRESET
  logic        rd_vel;     // Read hits REG_VEL
  logic        vel_upd;    // Sticky new-velocity flag
  enc_status_t status;
  reg_data_t   rd_data;    // Read mux output

  assign wr_ctrl   = bus_wr && (bus_addr == REG_CTRL);
  assign wr_cmd    = bus_wr && (bus_addr == REG_CMD);
  assign wr_preset = bus_wr && (bus_addr == REG_PRESET);
  assign rd_vel    = bus_rd && (bus_addr == REG_VEL);

  // Enable level set on by reset
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ctrl.enable <= 1'b1;
    end else if (wr_ctrl) begin
      ctrl.enable <= bus_wdata[CTRL_ENABLE_BIT];
    end
  end

  // Preset value also readable on the bus
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ctrl.preset_value <= '0;
    end else if (wr_preset) begin
      ctrl.preset_value <= enc_count_t'(bus_wdata);
    end
  end

  // Command bits become single-cycle pulses
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ctrl.count_clear <= 1'b0;
      ctrl.fault_clear <= 1'b0;
      ctrl.preset_load <= 1'b0;
    end else begin
      ctrl.count_clear <= wr_cmd && bus_wdata[CMD_CLR_COUNT_BIT];
      ctrl.fault_clear <= wr_cmd && bus_wdata[CMD_CLR_FAULT_BIT];
      ctrl.preset_load <= wr_cmd && bus_wdata[CMD_LOAD_PRESET_BIT];
    end
  end

  // Set by a closed window, cleared by reading REG_VEL
  always_ff @(posedge clk) begin
    if (!resetn) begin
      vel_upd <= 1'b0;
    end else if (ctrl.vel_valid) begin
      vel_upd <= 1'b1;  // New value beats a read
    end else if (rd_vel) begin
      vel_upd <= 1'b0;
    end
  end

  always_comb begin
    status                    = '0;
    status[STATUS_FAULTN_BIT] = ctrl.faultn;
    status[STATUS_VUPD_BIT]   = vel_upd;
  end

  // Read mux where unmapped and write-only addresses read as zero
  always_comb begin
    rd_data = '0;
    case (bus_addr)
      REG_CTRL:   rd_data[CTRL_ENABLE_BIT] = ctrl.enable;
      REG_PRESET: rd_data = reg_data_t'(ctrl.preset_value);
      REG_COUNT:  rd_data = reg_data_t'(ctrl.count);
      REG_VEL: begin
        // Sign-extend to bus width
        rd_data = {{(REG_DATA_W - `ENC_VEL_W){ctrl.velocity[`ENC_VEL_W-1]}},
                   ctrl.velocity};
      end
      REG_STATUS: rd_data = reg_data_t'(status);
      default:    rd_data = '0;
    endcase
  end

  // Holds until the next read
  always_ff @(posedge clk) begin
    if (!resetn) begin
      bus_rdata <= '0;
    end else if (bus_rd) begin
      bus_rdata <= rd_data;
    end
  end

endmodule

// ==== logic/velocity_meter.sv ====
`timescale 1ns/1ps
`include "enc_cfg.svh"

module velocity_meter (
  input  logic    clk,
  input  logic    resetn,
  input  logic    step,  // Step pulse from decoder
  input  logic    dir,   // Direction of that step
  enc_ctrl_if.vel ctrl
);
  import enc_types_pkg::*;

  localparam int GATE_W = $clog2(`ENC_GATE_CYCLES);  // Gate counter bits

  logic [GATE_W-1:0] gate_cnt;   // Cycle within the window
  logic              gate_end;   // Last cycle of the window
  enc_vel_t          acc;        // Running net step count
  enc_vel_t          delta;      // This cycle's contribution

  assign gate_end = (gate_cnt == GATE_W'(`ENC_GATE_CYCLES - 1));

  // Plus one up, minus one down, zero when idle
  always_comb begin
    if (!step) begin
      delta = '0;
    end else if (dir) begin
      delta = enc_vel_t'(1);
    end else begin
      delta = enc_vel_t'(-1);
    end
  end

  // Free-running window from reset release
  always_ff @(posedge clk) begin
    if (!resetn) begin
      gate_cnt <= '0;
    end else if (gate_end) begin
      gate_cnt <= '0;
    end else begin
      gate_cnt <= gate_cnt + GATE_W'(1);
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      acc            <= '0;
      ctrl.velocity  <= '0;
      ctrl.vel_valid <= 1'b0;
    end else if (gate_end) begin
      ctrl.velocity  <= acc;    // Close the window
      ctrl.vel_valid <= 1'b1;
      acc            <= delta;  // End-cycle step opens the next window
    end else begin
      acc            <= acc + delta;
      ctrl.vel_valid <= 1'b0;
    end
  end

endmodule

// ==== logic/quad_decoder.sv ====
`timescale 1ns/1ps

module quad_decoder (
  input  logic    clk,
  input  logic    resetn,
  input  logic    a,       // Asynchronous channel A pin
  input  logic    b,       // Asynchronous channel B pin
  enc_ctrl_if.dec ctrl,
  output logic    step,    // One cycle per legal transition
  output logic    dir      // High when A leads B
);
  import enc_types_pkg::*;

  logic [2:0] a_sync;      // Two sync stages plus previous sample
  logic [2:0] b_sync;
  logic       a_chg;       // A moved since last sample
  logic       b_chg;       // B moved since last sample
  logic       one_chg;     // Exactly one channel moved
  logic       double_chg;  // Both moved so direction is lost
  enc_count_t count_nxt;

  // Sync chain for both channels
  always_ff @(posedge clk) begin
    a_sync <= {a_sync[1:0], a};  // Shift in new A
    b_sync <= {b_sync[1:0], b};  // Shift in new B
  end

  assign a_chg      = a_sync[1] ^ a_sync[2];
  assign b_chg      = b_sync[1] ^ b_sync[2];
  assign one_chg    = a_chg ^ b_chg;   // Legal Gray transition
  assign double_chg = a_chg & b_chg;   // Illegal, both in one sample

  // Steps only while enabled
  assign step = one_chg & ctrl.enable;

  // Current A against previous B gives the sense of rotation
  assign dir = a_sync[1] ^ b_sync[2];

  // Clear beats preset, preset beats a step
  always_comb begin
    count_nxt = ctrl.count;                       // Hold by default
    if (ctrl.count_clear) begin
      count_nxt = '0;                             // Software clear
    end else if (ctrl.preset_load) begin
      count_nxt = ctrl.preset_value;              // Software preset
    end else if (step) begin
      if (dir) begin
        count_nxt = ctrl.count + enc_count_t'(1); // Up
      end else begin
        count_nxt = ctrl.count - enc_count_t'(1); // Down
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ctrl.count <= '0;
    end else begin
      ctrl.count <= count_nxt;
    end
  end

  // Sticky fault where a new double change wins over a clear
  always_ff @(posedge clk) begin
    if (!resetn) begin
      ctrl.faultn <= 1'b1;
    end else if (double_chg) begin
      ctrl.faultn <= 1'b0;  // Lost track of position
    end else if (ctrl.fault_clear) begin
      ctrl.faultn <= 1'b1;
    end
  end

  // Synchronizers and fault check keep running while disabled

endmodule

// ==== logic/enc_ctrl_if.sv ====
`timescale 1ns/1ps

interface enc_ctrl_if;
  import enc_types_pkg::*;

  logic       enable;        // Step gating level
  logic       count_clear;   // One-cycle pulse
  logic       fault_clear;   // One-cycle pulse
  logic       preset_load;   // One-cycle pulse
  enc_count_t preset_value;  // Loaded on preset_load
  enc_count_t count;         // Live position
  logic       faultn;        // Sticky flag low on fault
  enc_vel_t   velocity;      // Last closed window
  logic       vel_valid;     // Pulse at window end

  // Register block side
  modport regs (
    output enable, count_clear, fault_clear, preset_load, preset_value,
    input  count, faultn, velocity, vel_valid
  );

  // Decoder side
  modport dec (
    input  enable, count_clear, fault_clear, preset_load, preset_value,
    output count, faultn
  );

  // Velocity meter side
  modport vel (output velocity, vel_valid);

endinterface

// ==== logic/enc_reg_pkg.sv ====
`include "enc_cfg.svh"

package enc_reg_pkg;

  localparam int REG_DATA_W = 32;  // Bus word width

  typedef logic [`ENC_ADDR_W-1:0] reg_addr_t;
  typedef logic [REG_DATA_W-1:0]  reg_data_t;

  // Register address map
  typedef enum reg_addr_t {
    REG_CTRL   = 0,  // Bit 0 enable
    REG_CMD    = 1,  // Write-only command bits
    REG_PRESET = 2,  // Value for preset load
    REG_COUNT  = 3,  // Read-only position count
    REG_VEL    = 4,  // Velocity sign-extended on read
    REG_STATUS = 5   // Fault and velocity-updated flags
  } reg_sel_e;

  localparam int CTRL_ENABLE_BIT     = 0;  // REG_CTRL enable
  localparam int CMD_CLR_COUNT_BIT   = 0;  // REG_CMD count clear
  localparam int CMD_CLR_FAULT_BIT   = 1;  // REG_CMD fault clear
  localparam int CMD_LOAD_PRESET_BIT = 2;  // REG_CMD preset load

endpackage

// ==== logic/enc_types_pkg.sv ====
`include "enc_cfg.svh"

package enc_types_pkg;

  // Position count that wraps in two's complement
  typedef logic signed [`ENC_COUNT_W-1:0] enc_count_t;

  // Net steps seen in one gate window
  typedef logic signed [`ENC_VEL_W-1:0] enc_vel_t;

  // Status word as seen on REG_STATUS
  typedef logic [1:0] enc_status_t;

  // Status bit positions
  localparam int STATUS_FAULTN_BIT = 0;  // Low after a double change
  localparam int STATUS_VUPD_BIT   = 1;  // New velocity not yet read

endpackage

// ==== enc_cfg.svh ====
`ifndef ENC_CFG_SVH
`define ENC_CFG_SVH

// Position counter width
`define ENC_COUNT_W 32

// Signed steps per gate window
`define ENC_VEL_W 16

// Gate window in clk cycles
`define ENC_GATE_CYCLES 1000

// Register bus address bits
`define ENC_ADDR_W 3

`endif
